/* mipsCore.f */
+incdir+hw
hw/isaPkg.sv
hw/corePkg.sv
hw/registerFile.sv
hw/aluUnit.sv
hw/memPort.sv
hw/controlUnit.sv
hw/datapath.sv
hw/mipsCore.sv
verif/clockGen.sv
verif/mipsCore_sva.sv
verif/mipsCoreTb.sv

/* verif/mipsCore_golden.txt */
# M byte-address word loads one memory word, hex
# E name byte-address data is one expected store in program order, hex
M 000 8C010100
M 004 8C020104
M 008 00221820
M 00C AC030180
M 010 00222022
M 014 AC040184
M 018 00222824
M 01C AC050188
M 020 00223025
M 024 AC06018C
M 028 00223826
M 02C AC070190
M 030 00224027
M 034 AC080194
M 038 0022482A
M 03C AC090198
M 040 0022502B
M 044 AC0A019C
M 048 204BFFFB
M 04C AC0B01A0
M 050 302CF00F
M 054 AC0C01A4
M 058 342D8421
M 05C AC0D01A8
M 060 382EFFFF
M 064 AC0E01AC
M 068 3C0FBEEF
M 06C AC0F01B0
M 070 8C100108
M 074 AC1001B4
M 078 20200001
M 07C AC0001B8
M 100 8000000F
M 104 000000F3
M 108 CAFEF00D
E add 180 80000102
E sub 184 7FFFFF1C
E and 188 00000003
E or 18C 800000FF
E xor 190 800000FC
E nor 194 7FFFFF00
E slt 198 00000001
E sltu 19C 00000000
E addiNeg 1A0 000000EE
E andi 1A4 0000000F
E ori 1A8 8000842F
E xori 1AC 8000FFF0
E lui 1B0 BEEF0000
E lwSw 1B4 CAFEF00D
E zeroReg 1B8 00000000

/* verif/mipsCoreTb.sv */
`timescale 1ns/10ps
`include "mips_config.svh"

module mipsCoreTb import corePkg::*; ();
	localparam int MEM_WORDS = (1 << `ADDR_WIDTH) / `WORD_BYTES;
	localparam int CYCLES_PER_WORD = 60;

	logic CLK, reset;
	memReq_t memReq;
	logic req, ack;
	logic [`DATA_WIDTH-1:0] rdata;

	logic [`DATA_WIDTH-1:0] mem [MEM_WORDS]; // Word memory model
	string recName[$]; // Expected stores in program order
	logic [31:0] recAddr[$];
	logic [31:0] recData[$];
	int nextRec;
	int loadedWords;
	int passCount, failCount, errorCount;
	int cycles, cycleLimit;
	logic [31:0] seed;
	int delay;
	logic busy; // Request seen and ack pending
	logic seenFirst;

	clockGen clkGen (
		.CLK(CLK),
		.reset(reset)
	);

	mipsCore UUT (
		.CLK(CLK),
		.reset(reset),
		.memReq(memReq),
		.req(req),
		.ack(ack),
		.rdata(rdata)
	);

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic checkValue(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected === actual) begin
			passCount++;
			$display("PASS %0s value 0x%08h", testName, actual);
		end else begin
			failCount++;
			$display("FAIL %0s expected 0x%08h actual 0x%08h", testName, expected, actual);
		end
	endtask

	// M lines fill memory and E lines queue expected stores
	task automatic loadGolden();
		int fd;
		int n;
		string line;
		string nm;
		logic [31:0] a, d;
		fd = $fopen("verif/mipsCore_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden file verif/mipsCore_golden.txt");
			errorCount++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n == 0 || line.len() == 0 || line[0] == "#")
				continue;
			if ($sscanf(line, "M %h %h", a, d) == 2) begin
				mem[a[`ADDR_WIDTH-1:2]] = d; // Byte address to word index
				loadedWords++;
			end else if ($sscanf(line, "E %s %h %h", nm, a, d) == 3) begin
				recName.push_back(nm);
				recAddr.push_back(a);
				recData.push_back(d);
			end
		end
		$fclose(fd);
	endtask

	// Access done once the random delay runs out
	task automatic serveAccess();
		logic [31:0] idx;
		idx = 32'(memReq.addr[`ADDR_WIDTH-1:2]);
		if (memReq.write) begin
			mem[idx] = memReq.wdata;
			if (nextRec < recName.size()) begin
				checkValue({recName[nextRec], " addr"}, recAddr[nextRec], 32'(memReq.addr));
				checkValue({recName[nextRec], " data"}, recData[nextRec], memReq.wdata);
				nextRec++;
			end else begin
				$display("Unexpected store to address 0x%03h after the last expected store",
					memReq.addr);
				errorCount++;
			end
		end else begin
			rdata = mem[idx];
		end
	endtask

	// Four-phase memory side driven on falling edges
	always @(negedge CLK) begin
		if (reset) begin
			ack = 1'b0;
			busy = 1'b0;
		end else if (ack) begin
			if (!req)
				ack = 1'b0; // Phase 4
		end else if (req) begin
			if (!busy) begin
				busy = 1'b1;
				seed = lcgNext(seed);
				delay = int'(seed[17:16]); // 0 to 3 cycles
				if (!seenFirst) begin
					seenFirst = 1'b1;
					checkValue("firstFetch write", 32'd0, 32'(memReq.write));
					checkValue("firstFetch addr", 32'd0, 32'(memReq.addr));
				end
			end
			if (delay == 0) begin
				serveAccess();
				ack = 1'b1;
				busy = 1'b0;
			end else begin
				delay--;
			end
		end
	end

	initial begin
		ack = 1'b0;
		rdata = '0;
		seed = 32'd73;
		delay = 0;
		busy = 1'b0;
		seenFirst = 1'b0;
		nextRec = 0;
		loadedWords = 0;
		passCount = 0;
		failCount = 0;
		errorCount = 0;
		cycles = 0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = 32'hA500_0000 | 32'(i); // Unused opcode acts as no-op
		loadGolden();
		if (recName.size() == 0) begin
			$display("The golden file holds no expected stores");
			errorCount++;
		end
		cycleLimit = CYCLES_PER_WORD * loadedWords;
		@(negedge reset);
		while (nextRec < recName.size() && cycles < cycleLimit) begin
			@(posedge CLK);
			cycles++;
		end
		if (nextRec < recName.size()) begin
			$display("Timeout after %0d cycles with %0d expected stores missing",
				cycles, recName.size() - nextRec);
			errorCount++;
		end
		if (UUT.busChecks.assertFails != 0) begin
			$display("Bus protocol assertions failed %0d times",
				UUT.busChecks.assertFails);
			errorCount++;
		end
		$display("Checks passed %0d, failed %0d, other errors %0d",
			passCount, failCount, errorCount);
		if (failCount == 0 && errorCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* verif/mipsCore_sva.sv */
`timescale 1ns/10ps

module mipsCoreSva import corePkg::*; (
	input logic CLK,
	input logic reset,
	input logic req,
	input logic ack,
	input memReq_t memReq
);
	int assertFails = 0; // Read by the testbench at the end

	// New request only once the previous ack is gone
	assert property (@(posedge CLK) disable iff (reset) $rose(req) |-> !$past(ack))
		else begin
			assertFails++;
			$error("req rose while ack was still high");
		end

	// Payload frozen for the whole request
	assert property (@(posedge CLK) disable iff (reset) (req && $past(req)) |-> $stable(memReq))
		else begin
			assertFails++;
			$error("memReq changed while req was high");
		end

	// Release only after the memory answered
	assert property (@(posedge CLK) disable iff (reset) $fell(req) |-> $past(ack))
		else begin
			assertFails++;
			$error("req dropped before ack rose");
		end

	assert property (@(posedge CLK) (reset && $past(reset)) |-> !req)
		else begin
			assertFails++;
			$error("req high during reset");
		end

endmodule

bind mipsCore mipsCoreSva busChecks (
	.CLK(CLK),
	.reset(reset),
	.req(req),
	.ack(ack),
	.memReq(memReq)
);

/* verif/clockGen.sv */
`timescale 1ns/10ps

module clockGen (
	output logic CLK,
	output logic reset
);
	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK; // 4 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (10) @(posedge CLK);
		@(negedge CLK) reset = 1'b0; // Released on a falling edge
	end

endmodule

/* hw/mipsCore.sv */
`timescale 1ns/10ps
`include "mips_config.svh"

module mipsCore import isaPkg::*; import corePkg::*; (
	input logic CLK,
	input logic reset,
	output memReq_t memReq,
	output logic req,
	input logic ack,
	input logic [`DATA_WIDTH-1:0] rdata
);
	ctrlWord_t ctrl;
	instr_t instr;
	logic [`ADDR_WIDTH-1:0] addr;
	logic [`DATA_WIDTH-1:0] storeData;
	logic [`DATA_WIDTH-1:0] memData; // Last read word
	logic memDone;

	controlUnit ctrlUnit (
		.CLK(CLK),
		.reset(reset),
		.memDone(memDone),
		.instr(instr),
		.ctrl(ctrl)
	);

	datapath dp (
		.CLK(CLK),
		.reset(reset),
		.ctrl(ctrl),
		.memData(memData),
		.instr(instr),
		.addr(addr),
		.storeData(storeData)
	);

	// Only external access path
	memPort mem (
		.CLK(CLK),
		.reset(reset),
		.memStart(ctrl.memStart),
		.memWrite(ctrl.memWrite),
		.addr(addr),
		.storeData(storeData),
		.memDone(memDone),
		.memData(memData),
		.memReq(memReq),
		.req(req),
		.ack(ack),
		.rdata(rdata)
	);

endmodule

/* hw/datapath.sv */
`timescale 1ns/10ps
`include "mips_config.svh"

module datapath import isaPkg::*; import corePkg::*; (
	input logic CLK,
	input logic reset,
	input ctrlWord_t ctrl,
	input logic [`DATA_WIDTH-1:0] memData,
	output instr_t instr,
	output logic [`ADDR_WIDTH-1:0] addr,
	output logic [`DATA_WIDTH-1:0] storeData
);
	logic [`ADDR_WIDTH-1:0] pc;
	instrWord_t ir;
	logic [`REG_ADDR_WIDTH-1:0] wrAddr;
	logic [`DATA_WIDTH-1:0] wrData;
	logic [`DATA_WIDTH-1:0] rsData, rtData;
	logic [`DATA_WIDTH-1:0] signImm, zeroImm;
	logic [`DATA_WIDTH-1:0] aluB, aluResult;

	// PC and instruction register
	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
			ir <= '0;
		end else begin
			if (ctrl.pcLd)
				pc <= pc + `ADDR_WIDTH'(`WORD_BYTES);
			if (ctrl.irLd)
				ir <= instrWord_t'(memData);
		end
	end

	assign instr = ir.r;

	// Immediate extension
	assign signImm = {{(`DATA_WIDTH-`IMM_WIDTH){ir.i.imm[`IMM_WIDTH-1]}}, ir.i.imm};
	assign zeroImm = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, ir.i.imm}; // andi/ori/xori/lui

	always_comb begin
		case (ctrl.aluSrcSel)
			srcSignImm: aluB = signImm;
			srcZeroImm: aluB = zeroImm;
			default: aluB = rtData;
		endcase
	end

	// Write-back routing
	assign wrAddr = (ctrl.regDstSel == dstRd) ? instr.rd : instr.rt;
	assign wrData = (ctrl.regInSel == selMem) ? memData : aluResult;

	// Fetch from PC, data access from effective address
	assign addr = (ctrl.addrSel == addrAlu) ? aluResult[`ADDR_WIDTH-1:0] : pc;
	assign storeData = rtData; // sw source

	registerFile regFile (
		.CLK(CLK),
		.reset(reset),
		.writeEn(ctrl.regWrite),
		.rsAddr(instr.rs),
		.rtAddr(instr.rt),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rsData(rsData),
		.rtData(rtData)
	);

	aluUnit alu (
		.aluOp(ctrl.aluOp),
		.funct(instr.funct),
		.a(rsData),
		.b(aluB),
		.result(aluResult)
	);

endmodule

/* hw/controlUnit.sv */
`timescale 1ns/10ps
`include "mips_config.svh"

module controlUnit import isaPkg::*; import corePkg::*; (
	input logic CLK,
	input logic reset,
	input logic memDone,
	input instr_t instr,
	output ctrlWord_t ctrl
);
	ctrlState_t state, nextState;
	logic armed; // Holds off the first fetch for a cycle after reset
	logic isAlu, isMem;
	ctrlWord_t execWord; // Opcode dependent datapath fields only

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= stFetch;
			armed <= 1'b0;
		end else begin
			state <= nextState;
			armed <= 1'b1;
		end
	end

	// Opcode class and operand routing
	always_comb begin
		execWord = '0;
		isAlu = 1'b1;
		isMem = 1'b0;
		case (instr.opcode)
			opRtype: begin
				execWord.aluOp = aluFunct;
				execWord.regDstSel = dstRd; // rd for R-type only
			end
			opAddi, opAddiu: begin
				execWord.aluSrcSel = srcSignImm; // Overflow ignored for both
			end
			opSlti: begin
				execWord.aluOp = aluSlt;
				execWord.aluSrcSel = srcSignImm;
			end
			opSltiu: begin
				execWord.aluOp = aluSltu;
				execWord.aluSrcSel = srcSignImm; // Sign extended, compared unsigned
			end
			opAndi: begin
				execWord.aluOp = aluAnd;
				execWord.aluSrcSel = srcZeroImm;
			end
			opOri: begin
				execWord.aluOp = aluOr;
				execWord.aluSrcSel = srcZeroImm;
			end
			opXori: begin
				execWord.aluOp = aluXor;
				execWord.aluSrcSel = srcZeroImm;
			end
			opLui: begin
				execWord.aluOp = aluLui;
				execWord.aluSrcSel = srcZeroImm;
			end
			opLw, opSw: begin
				isAlu = 1'b0;
				isMem = 1'b1;
				execWord.aluSrcSel = srcSignImm; // Base plus offset
				execWord.regInSel = selMem; // Only used by lw write-back
			end
			default: isAlu = 1'b0; // Unknown opcode, no-op
		endcase
	end

	// Next state
	always_comb begin
		nextState = state;
		case (state)
			stFetch: nextState = armed ? stFetchWait : stFetch;
			stFetchWait: if (memDone) nextState = stDecode;
			stDecode: begin
				if (isAlu)
					nextState = stExecute;
				else if (isMem)
					nextState = stMemAddr;
				else
					nextState = stFetch;
			end
			stExecute: nextState = stWriteBack;
			stMemAddr: nextState = stMemWait;
			stMemWait: begin
				if (memDone)
					nextState = (instr.opcode == opLw) ? stWriteBack : stFetch;
			end
			stWriteBack: nextState = stFetch;
			default: nextState = stFetch;
		endcase
	end

	// Control word per state
	always_comb begin
		ctrl = '0;
		case (state)
			stFetch: ctrl.memStart = armed; // PC address, read
			stFetchWait: begin
				ctrl.irLd = memDone;
				ctrl.pcLd = memDone;
			end
			stExecute: ctrl = execWord;
			stMemAddr: begin
				ctrl = execWord;
				ctrl.addrSel = addrAlu;
				ctrl.memStart = 1'b1;
				ctrl.memWrite = (instr.opcode == opSw);
			end
			stMemWait: begin
				ctrl = execWord;
				ctrl.addrSel = addrAlu;
			end
			stWriteBack: begin
				ctrl = execWord;
				ctrl.regWrite = 1'b1;
			end
			default: ctrl = '0; // stDecode idles
		endcase
	end

endmodule

/* hw/memPort.sv */
`timescale 1ns/10ps
`include "mips_config.svh"

module memPort import corePkg::*; (
	input logic CLK,
	input logic reset,
	input logic memStart,
	input logic memWrite,
	input logic [`ADDR_WIDTH-1:0] addr,
	input logic [`DATA_WIDTH-1:0] storeData,
	output logic memDone,
	output logic [`DATA_WIDTH-1:0] memData,
	output memReq_t memReq,
	output logic req,
	input logic ack,
	input logic [`DATA_WIDTH-1:0] rdata
);
	typedef enum logic [1:0] {phIdle, phRequest, phRelease} busPhase_t;

	busPhase_t phase;

	// Four-phase handshake sequencer
	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= phIdle;
			req <= 1'b0;
			memDone <= 1'b0;
		end else begin
			memDone <= 1'b0; // Single cycle pulse
			case (phase)
				phIdle: begin
					if (memStart) begin
						req <= 1'b1; // ack already low here
						phase <= phRequest;
					end
				end
				phRequest: begin
					if (ack) begin
						req <= 1'b0;
						phase <= phRelease;
					end
				end
				phRelease: begin
					if (!ack) begin
						memDone <= 1'b1;
						phase <= phIdle;
					end
				end
				default: phase <= phIdle;
			endcase
		end
	end

	// MAR/MDR style payload, held for the whole request
	always_ff @(posedge CLK) begin
		if (phase == phIdle && memStart) begin
			memReq.write <= memWrite;
			memReq.addr <= addr;
			memReq.wdata <= storeData;
		end
		if (phase == phRequest && ack && !memReq.write)
			memData <= rdata; // Read word captured with ack
	end

endmodule

/* hw/aluUnit.sv */
`timescale 1ns/10ps
`include "mips_config.svh"

module aluUnit import isaPkg::*; import corePkg::*; (
	input aluOp_t aluOp,
	input funct_t funct,
	input logic [`DATA_WIDTH-1:0] a,
	input logic [`DATA_WIDTH-1:0] b,
	output logic [`DATA_WIDTH-1:0] result
);
	logic [`DATA_WIDTH-1:0] sum, diff, lessSigned, lessUnsigned, upper;

	// Shared results, wraparound on overflow
	assign sum = a + b;
	assign diff = a - b;
	assign lessSigned = {{(`DATA_WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
	assign lessUnsigned = {{(`DATA_WIDTH-1){1'b0}}, a < b};
	assign upper = b << `IMM_WIDTH; // lui

	always_comb begin
		case (aluOp)
			aluAdd: result = sum;
			aluSlt: result = lessSigned;
			aluSltu: result = lessUnsigned;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			aluLui: result = upper;
			aluFunct: begin
				// R-type, funct picks the operation
				case (funct)
					fnAdd, fnAddu: result = sum;
					fnSub, fnSubu: result = diff;
					fnAnd: result = a & b;
					fnOr: result = a | b;
					fnXor: result = a ^ b;
					fnNor: result = ~(a | b);
					fnSlt: result = lessSigned;
					fnSltu: result = lessUnsigned;
					default: result = '0; // Unsupported funct
				endcase
			end
			default: result = '0;
		endcase
	end

endmodule

/* hw/registerFile.sv */
`timescale 1ns/10ps
`include "mips_config.svh"

module registerFile (
	input logic CLK,
	input logic reset,
	input logic writeEn,
	input logic [`REG_ADDR_WIDTH-1:0] rsAddr,
	input logic [`REG_ADDR_WIDTH-1:0] rtAddr,
	input logic [`REG_ADDR_WIDTH-1:0] wrAddr,
	input logic [`DATA_WIDTH-1:0] wrData,
	output logic [`DATA_WIDTH-1:0] rsData,
	output logic [`DATA_WIDTH-1:0] rtData
);
	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (writeEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData; // $zero never written
		end
	end

	// Combinational read ports
	assign rsData = regs[rsAddr];
	assign rtData = regs[rtAddr];

endmodule

/* hw/corePkg.sv */
`include "mips_config.svh"

package corePkg;

	// Main FSM states
	typedef enum logic [2:0] {
		stFetch,
		stFetchWait, // Instruction read in flight
		stDecode,
		stExecute,
		stMemAddr,
		stMemWait,   // Data access in flight
		stWriteBack
	} ctrlState_t;

	// aluFunct hands the choice to the funct field
	typedef enum logic [2:0] {
		aluAdd,
		aluSlt,
		aluSltu,
		aluAnd,
		aluOr,
		aluXor,
		aluLui,
		aluFunct
	} aluOp_t;

	typedef enum logic {selAlu, selMem} regInSel_t; // Write-back source
	typedef enum logic {dstRt, dstRd} regDstSel_t; // Write-back register
	typedef enum logic [1:0] {srcReg, srcSignImm, srcZeroImm} aluSrcSel_t; // ALU operand B
	typedef enum logic {addrPc, addrAlu} addrSel_t; // Memory address source

	// All-zero word is the idle control
	typedef struct packed {
		logic pcLd;
		logic irLd;
		logic regWrite;
		regInSel_t regInSel;
		regDstSel_t regDstSel;
		aluSrcSel_t aluSrcSel;
		aluOp_t aluOp;
		addrSel_t addrSel;
		logic memStart;
		logic memWrite;
	} ctrlWord_t;

	typedef struct packed {
		logic write;
		logic [`ADDR_WIDTH-1:0] addr;
		logic [`DATA_WIDTH-1:0] wdata;
	} memReq_t;

endpackage

/* hw/isaPkg.sv */
`include "mips_config.svh"

package isaPkg;

	// Primary opcodes kept in the subset
	typedef enum logic [5:0] {
		opRtype = 6'b000000, // Decoded further by funct
		opAddi  = 6'b001000,
		opAddiu = 6'b001001,
		opSlti  = 6'b001010,
		opSltiu = 6'b001011,
		opAndi  = 6'b001100,
		opOri   = 6'b001101,
		opXori  = 6'b001110,
		opLui   = 6'b001111,
		opLw    = 6'b100011,
		opSw    = 6'b101011
	} opcode_t;

	// R-type function codes
	typedef enum logic [5:0] {
		fnAdd  = 6'b100000,
		fnAddu = 6'b100001,
		fnSub  = 6'b100010,
		fnSubu = 6'b100011,
		fnAnd  = 6'b100100,
		fnOr   = 6'b100101,
		fnXor  = 6'b100110,
		fnNor  = 6'b100111,
		fnSlt  = 6'b101010,
		fnSltu = 6'b101011
	} funct_t;

	typedef struct packed {
		opcode_t opcode;
		logic [`REG_ADDR_WIDTH-1:0] rs;
		logic [`REG_ADDR_WIDTH-1:0] rt;
		logic [`REG_ADDR_WIDTH-1:0] rd;
		logic [4:0] shamt; // Unused, no shifts
		funct_t funct;
	} instr_t;

	// Same word seen as R-type fields or as upper half plus immediate
	typedef union packed {
		instr_t r;
		struct packed {
			logic [`DATA_WIDTH-`IMM_WIDTH-1:0] upper;
			logic [`IMM_WIDTH-1:0] imm;
		} i;
	} instrWord_t;

endpackage

/* hw/mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Machine word and register file geometry
`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5 // rs/rt/rd field width
`define REG_COUNT 32

// Byte addressed memory, 512 bytes
`define ADDR_WIDTH 9

// PC step, one word per instruction
`define WORD_BYTES 4

// Immediate field of I-type words
`define IMM_WIDTH 16

`endif
